// ==== design/exe_settings.svh ====
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// Register data width in bits
`define EXE_XLEN 32

// Program counter and branch target width
`define EXE_PADDR_W 32

// Register stages after EX0
`define EXE_NUM_STAGES 1

`endif

// ==== design/common_pkg.sv ====
`include "exe_settings.svh"

package common_pkg;

    // One architectural register value
    typedef logic [`EXE_XLEN-1:0] t_rv_reg_data;

    // Program counter or branch target
    typedef logic [`EXE_PADDR_W-1:0] t_paddr;

endpackage

// ==== design/instr_pkg.sv ====
package instr_pkg;

    // Micro-ops handled by the execute stage
    typedef enum logic [4:0] {
        U_INVALID,
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_LUI,
        U_BEQ,
        U_BNE,
        U_BLT,
        U_BGE,
        U_BLTU,
        U_BGEU,
        U_JAL,
        U_JALR
    } t_uop;

    // Where the second operand comes from
    typedef enum logic [1:0] {
        OP_REG,
        OP_IMM,
        OP_NONE
    } t_optype;

    // Decoded micro-instruction as it leaves register read
    typedef struct packed {
        logic               valid;
        t_uop               uop;
        t_optype            src2_optype;
        logic [31:0]        imm32;
        common_pkg::t_paddr pc;
        logic [4:0]         rd;
    } t_uinstr;

endpackage

// ==== design/exe_unit_if.sv ====
`timescale 1ns/10ps

interface exe_unit_if;

    logic                     valid;
    instr_pkg::t_uop          uop;
    common_pkg::t_paddr       pc;
    logic [31:0]              imm32;
    common_pkg::t_rv_reg_data src1val;
    // Already selected between register and immediate
    common_pkg::t_rv_reg_data src2val;

    modport issue (
        output valid,
        output uop,
        output pc,
        output imm32,
        output src1val,
        output src2val
    );

    modport unit (
        input valid,
        input uop,
        input pc,
        input imm32,
        input src1val,
        input src2val
    );

endinterface

// ==== design/exe_stage_reg.sv ====
`timescale 1ns/10ps

module exe_stage_reg #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    input  T     d,
    output T     q
);

    T stage_q [DEPTH];

    // Whole chain freezes together on stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (!stall) begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[DEPTH-1];

endmodule

// ==== design/ialu.sv ====
`timescale 1ns/10ps

module ialu (
    input  logic                     clk,
    input  logic                     rst_n,
    exe_unit_if.unit                 issue,
    output logic                     resvld,
    output common_pkg::t_rv_reg_data result
);

    logic       is_alu;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // RV32 shifts only look at the low five bits
    assign shamt = issue.src2val[4:0];

    assign lt_s = $signed(issue.src1val) < $signed(issue.src2val);
    assign lt_u = issue.src1val < issue.src2val;

    always_comb begin
        is_alu = 1'b1;
        result = '0;
        case (issue.uop)
            instr_pkg::U_ADD: begin
                result = issue.src1val + issue.src2val;
            end
            instr_pkg::U_SUB: begin
                result = issue.src1val - issue.src2val;
            end
            instr_pkg::U_AND: begin
                result = issue.src1val & issue.src2val;
            end
            instr_pkg::U_OR: begin
                result = issue.src1val | issue.src2val;
            end
            instr_pkg::U_XOR: begin
                result = issue.src1val ^ issue.src2val;
            end
            instr_pkg::U_SLL: begin
                result = issue.src1val << shamt;
            end
            instr_pkg::U_SRL: begin
                result = issue.src1val >> shamt;
            end
            instr_pkg::U_SRA: begin
                result = common_pkg::t_rv_reg_data'($signed(issue.src1val) >>> shamt);
            end
            instr_pkg::U_SLT: begin
                result = common_pkg::t_rv_reg_data'(lt_s);
            end
            instr_pkg::U_SLTU: begin
                result = common_pkg::t_rv_reg_data'(lt_u);
            end
            // Decode has already placed the immediate in the upper bits
            instr_pkg::U_LUI: begin
                result = issue.src2val;
            end
            default: begin
                is_alu = 1'b0;
            end
        endcase
    end

    assign resvld = issue.valid & is_alu;

endmodule

// ==== design/ibr.sv ====
`timescale 1ns/10ps

module ibr (
    input  logic                     clk,
    input  logic                     rst_n,
    exe_unit_if.unit                 issue,
    output logic                     resvld,
    output common_pkg::t_rv_reg_data link,
    output common_pkg::t_paddr       br_tgt,
    output logic                     br_mispred
);

    logic               is_br;
    logic               is_jump;
    logic               taken;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    common_pkg::t_paddr pc_rel_tgt;
    common_pkg::t_paddr jalr_sum;

    assign eq   = issue.src1val == issue.src2val;
    assign lt_s = $signed(issue.src1val) < $signed(issue.src2val);
    assign lt_u = issue.src1val < issue.src2val;

    assign pc_rel_tgt = issue.pc + common_pkg::t_paddr'(issue.imm32);
    assign jalr_sum   = common_pkg::t_paddr'(issue.src1val)
                      + common_pkg::t_paddr'(issue.imm32);

    always_comb begin
        is_br   = 1'b1;
        is_jump = 1'b0;
        taken   = 1'b0;
        case (issue.uop)
            instr_pkg::U_BEQ: begin
                taken = eq;
            end
            instr_pkg::U_BNE: begin
                taken = !eq;
            end
            instr_pkg::U_BLT: begin
                taken = lt_s;
            end
            instr_pkg::U_BGE: begin
                taken = !lt_s;
            end
            instr_pkg::U_BLTU: begin
                taken = lt_u;
            end
            instr_pkg::U_BGEU: begin
                taken = !lt_u;
            end
            instr_pkg::U_JAL, instr_pkg::U_JALR: begin
                is_jump = 1'b1;
                taken   = 1'b1;
            end
            default: begin
                is_br = 1'b0;
            end
        endcase
    end

    // JALR target always has bit 0 cleared
    assign br_tgt = (issue.uop == instr_pkg::U_JALR)
                  ? (jalr_sum & ~common_pkg::t_paddr'(1))
                  : pc_rel_tgt;

    assign link = is_jump ? common_pkg::t_rv_reg_data'(issue.pc + common_pkg::t_paddr'(4))
                          : '0;

    assign resvld = issue.valid & is_br;

    // Static not-taken prediction, so every taken branch redirects
    assign br_mispred = issue.valid & taken;

endmodule

// ==== design/exe.sv ====
`timescale 1ns/10ps

`include "exe_settings.svh"

module exe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  instr_pkg::t_uinstr       uinstr_rd1,
    input  common_pkg::t_rv_reg_data rddata0_rd1,
    input  common_pkg::t_rv_reg_data rddata1_rd1,
    output common_pkg::t_paddr       br_tgt_ex0,
    output logic                     br_mispred_ex0,
    output instr_pkg::t_uinstr       uinstr_ex1,
    output common_pkg::t_rv_reg_data result_ex1
);

    common_pkg::t_rv_reg_data src2val_ex0;
    common_pkg::t_rv_reg_data result_ex0;

    logic                     ialu_resvld_ex0;
    common_pkg::t_rv_reg_data ialu_result_ex0;
    logic                     ibr_resvld_ex0;
    common_pkg::t_rv_reg_data ibr_link_ex0;

    exe_unit_if issue_if ();

    // Second operand select
    always_comb begin
        case (uinstr_rd1.src2_optype)
            instr_pkg::OP_REG: src2val_ex0 = rddata1_rd1;
            instr_pkg::OP_IMM: src2val_ex0 = common_pkg::t_rv_reg_data'(uinstr_rd1.imm32);
            default:           src2val_ex0 = '0;
        endcase
    end

    assign issue_if.valid   = uinstr_rd1.valid;
    assign issue_if.uop     = uinstr_rd1.uop;
    assign issue_if.pc      = uinstr_rd1.pc;
    assign issue_if.imm32   = uinstr_rd1.imm32;
    assign issue_if.src1val = rddata0_rd1;
    assign issue_if.src2val = src2val_ex0;

    ialu u_ialu (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue_if),
        .resvld (ialu_resvld_ex0),
        .result (ialu_result_ex0)
    );

    ibr u_ibr (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue_if),
        .resvld     (ibr_resvld_ex0),
        .link       (ibr_link_ex0),
        .br_tgt     (br_tgt_ex0),
        .br_mispred (br_mispred_ex0)
    );

    // At most one unit claims a micro-op
    assign result_ex0 = (ialu_resvld_ex0 ? ialu_result_ex0 : '0)
                      | (ibr_resvld_ex0  ? ibr_link_ex0    : '0);

    exe_stage_reg #(
        .T     (instr_pkg::t_uinstr),
        .DEPTH (`EXE_NUM_STAGES)
    ) u_uinstr_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .d     (uinstr_rd1),
        .q     (uinstr_ex1)
    );

    exe_stage_reg #(
        .T     (common_pkg::t_rv_reg_data),
        .DEPTH (`EXE_NUM_STAGES)
    ) u_result_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .d     (result_ex0),
        .q     (result_ex1)
    );

endmodule

// ==== design/exe_top.sv ====
`timescale 1ns/10ps

module exe_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  instr_pkg::t_uinstr       uinstr_rd1,
    input  common_pkg::t_rv_reg_data rddata0_rd1,
    input  common_pkg::t_rv_reg_data rddata1_rd1,
    // EX0 redirect
    output common_pkg::t_paddr       br_tgt_ex0,
    output logic                     br_mispred_ex0,
    // EX1 writeback
    output instr_pkg::t_uinstr       uinstr_ex1,
    output common_pkg::t_rv_reg_data result_ex1
);

    exe u_exe (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .uinstr_rd1     (uinstr_rd1),
        .rddata0_rd1    (rddata0_rd1),
        .rddata1_rd1    (rddata1_rd1),
        .br_tgt_ex0     (br_tgt_ex0),
        .br_mispred_ex0 (br_mispred_ex0),
        .uinstr_ex1     (uinstr_ex1),
        .result_ex1     (result_ex1)
    );

endmodule

// ==== tests/exe_clock_gen.sv ====
`timescale 1ns/10ps

module exe_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tests/exe_assertions.sv ====
`timescale 1ns/10ps

module exe_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     stall,
    input instr_pkg::t_uinstr       uinstr_rd1,
    input common_pkg::t_rv_reg_data rddata0_rd1,
    input common_pkg::t_rv_reg_data rddata1_rd1,
    input common_pkg::t_paddr       br_tgt_ex0,
    input logic                     br_mispred_ex0,
    input instr_pkg::t_uinstr       uinstr_ex1,
    input common_pkg::t_rv_reg_data result_ex1,
    input logic                     ialu_resvld,
    input logic                     ibr_resvld
);

    int result_errors = 0;
    int uinstr_errors = 0;
    int mispred_errors = 0;
    int target_errors = 0;
    int stall_errors = 0;
    int reset_errors = 0;
    int onehot_errors = 0;
    int error_count;

    logic                     checks_on = 1'b0;
    logic                     rst_applied;
    logic                     stall_applied;
    instr_pkg::t_uinstr       exp_uinstr;
    common_pkg::t_rv_reg_data exp_result;
    instr_pkg::t_uinstr       prev_uinstr;
    common_pkg::t_rv_reg_data prev_result;
    logic                     is_branch;
    logic                     exp_mispred;
    common_pkg::t_paddr       exp_tgt;

    function automatic common_pkg::t_rv_reg_data second_operand(
        instr_pkg::t_uinstr ui, common_pkg::t_rv_reg_data r1);
        case (ui.src2_optype)
            instr_pkg::OP_REG: return r1;
            instr_pkg::OP_IMM: return ui.imm32;
            default:           return '0;
        endcase
    endfunction

    function automatic logic branch_taken(instr_pkg::t_uop uop,
                                          common_pkg::t_rv_reg_data a,
                                          common_pkg::t_rv_reg_data b);
        case (uop)
            instr_pkg::U_BEQ:  return a == b;
            instr_pkg::U_BNE:  return a != b;
            instr_pkg::U_BLT:  return $signed(a) < $signed(b);
            instr_pkg::U_BGE:  return $signed(a) >= $signed(b);
            instr_pkg::U_BLTU: return a < b;
            instr_pkg::U_BGEU: return a >= b;
            instr_pkg::U_JAL, instr_pkg::U_JALR: return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic common_pkg::t_rv_reg_data expected_result(
        instr_pkg::t_uinstr ui, common_pkg::t_rv_reg_data a, common_pkg::t_rv_reg_data r1);
        common_pkg::t_rv_reg_data b;
        b = second_operand(ui, r1);
        if (!ui.valid) begin
            return '0;
        end
        case (ui.uop)
            instr_pkg::U_ADD:  return a + b;
            instr_pkg::U_SUB:  return a - b;
            instr_pkg::U_AND:  return a & b;
            instr_pkg::U_OR:   return a | b;
            instr_pkg::U_XOR:  return a ^ b;
            instr_pkg::U_SLL:  return a << b[4:0];
            instr_pkg::U_SRL:  return a >> b[4:0];
            instr_pkg::U_SRA:  return common_pkg::t_rv_reg_data'($signed(a) >>> b[4:0]);
            instr_pkg::U_SLT:  return {31'd0, $signed(a) < $signed(b)};
            instr_pkg::U_SLTU: return {31'd0, a < b};
            instr_pkg::U_LUI:  return b;
            // Link value for jumps, conditional branches write nothing
            instr_pkg::U_JAL, instr_pkg::U_JALR: return ui.pc + 32'd4;
            default:           return '0;
        endcase
    endfunction

    always_comb begin
        is_branch = uinstr_rd1.uop inside {instr_pkg::U_BEQ, instr_pkg::U_BNE,
                                           instr_pkg::U_BLT, instr_pkg::U_BGE,
                                           instr_pkg::U_BLTU, instr_pkg::U_BGEU,
                                           instr_pkg::U_JAL, instr_pkg::U_JALR};
        exp_mispred = uinstr_rd1.valid & branch_taken(uinstr_rd1.uop, rddata0_rd1,
                                                      second_operand(uinstr_rd1, rddata1_rd1));
        if (uinstr_rd1.uop == instr_pkg::U_JALR) begin
            exp_tgt = (rddata0_rd1 + uinstr_rd1.imm32) & 32'hFFFF_FFFE;
        end else begin
            exp_tgt = uinstr_rd1.pc + uinstr_rd1.imm32;
        end
    end

    // Reference copy of the EX1 register
    always_ff @(posedge clk) begin
        checks_on     <= 1'b1;
        rst_applied   <= rst_n;
        stall_applied <= stall;
        prev_uinstr   <= uinstr_ex1;
        prev_result   <= result_ex1;
        if (!rst_n) begin
            exp_uinstr <= '0;
            exp_result <= '0;
        end else if (!stall) begin
            exp_uinstr <= uinstr_rd1;
            exp_result <= expected_result(uinstr_rd1, rddata0_rd1, rddata1_rd1);
        end
    end

    assign error_count = result_errors + uinstr_errors + mispred_errors + target_errors
                       + stall_errors + reset_errors + onehot_errors;

    a_reset_clear: assert property (@(negedge clk) disable iff (!checks_on)
        !rst_applied |-> (!uinstr_ex1.valid && result_ex1 == '0))
        else begin
            reset_errors++;
            $error("[FAIL] reset_clear expected valid 0 result 0 actual valid %b result %h",
                   uinstr_ex1.valid, result_ex1);
        end

    a_ex1_result: assert property (@(negedge clk) disable iff (!checks_on)
        result_ex1 == exp_result)
        else begin
            result_errors++;
            $error("[FAIL] ex1_result expected %h actual %h", exp_result, result_ex1);
        end

    a_ex1_uinstr: assert property (@(negedge clk) disable iff (!checks_on)
        uinstr_ex1 == exp_uinstr)
        else begin
            uinstr_errors++;
            $error("[FAIL] ex1_uinstr expected %h actual %h", exp_uinstr, uinstr_ex1);
        end

    a_stall_hold: assert property (@(negedge clk) disable iff (!checks_on)
        (stall_applied && rst_applied) |->
            (result_ex1 == prev_result && uinstr_ex1 == prev_uinstr))
        else begin
            stall_errors++;
            $error("[FAIL] stall_hold expected result %h uinstr %h actual result %h uinstr %h",
                   prev_result, prev_uinstr, result_ex1, uinstr_ex1);
        end

    a_br_mispred: assert property (@(negedge clk) disable iff (!checks_on)
        br_mispred_ex0 == exp_mispred)
        else begin
            mispred_errors++;
            $error("[FAIL] br_mispred expected %b actual %b", exp_mispred, br_mispred_ex0);
        end

    a_br_target: assert property (@(negedge clk) disable iff (!checks_on)
        (uinstr_rd1.valid && is_branch) |-> br_tgt_ex0 == exp_tgt)
        else begin
            target_errors++;
            $error("[FAIL] br_target expected %h actual %h", exp_tgt, br_tgt_ex0);
        end

    a_unit_onehot: assert property (@(negedge clk) disable iff (!checks_on)
        (uinstr_rd1.valid && uinstr_rd1.uop != instr_pkg::U_INVALID) |->
            $onehot({ialu_resvld, ibr_resvld}))
        else begin
            onehot_errors++;
            $error("Not exactly one execute unit claimed a valid micro-op");
        end

endmodule

// ==== tests/exe_tb.sv ====
`timescale 1ns/10ps

module exe_tb;

    localparam int NUM_INSTR     = 2000;
    localparam int RESET_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = 6000;
    localparam int DRAIN_TIMEOUT = 10;

    logic                     clk;
    logic                     rst_n;
    logic                     stall;
    instr_pkg::t_uinstr       uinstr_rd1;
    common_pkg::t_rv_reg_data rddata0_rd1;
    common_pkg::t_rv_reg_data rddata1_rd1;
    common_pkg::t_paddr       br_tgt_ex0;
    logic                     br_mispred_ex0;
    instr_pkg::t_uinstr       uinstr_ex1;
    common_pkg::t_rv_reg_data result_ex1;

    logic [31:0] lcg_state = 32'h9869;
    int          issued;
    int          stalled;
    int          timeouts;
    int          assert_errors;

    exe_clock_gen #(
        .RESET_CYCLES (8)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exe_top u_exe_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .uinstr_rd1     (uinstr_rd1),
        .rddata0_rd1    (rddata0_rd1),
        .rddata1_rd1    (rddata1_rd1),
        .br_tgt_ex0     (br_tgt_ex0),
        .br_mispred_ex0 (br_mispred_ex0),
        .uinstr_ex1     (uinstr_ex1),
        .result_ex1     (result_ex1)
    );

    bind exe_top exe_assertions u_exe_assertions (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .uinstr_rd1     (uinstr_rd1),
        .rddata0_rd1    (rddata0_rd1),
        .rddata1_rd1    (rddata1_rd1),
        .br_tgt_ex0     (br_tgt_ex0),
        .br_mispred_ex0 (br_mispred_ex0),
        .uinstr_ex1     (uinstr_ex1),
        .result_ex1     (result_ex1),
        .ialu_resvld    (u_exe.ialu_resvld_ex0),
        .ibr_resvld     (u_exe.ibr_resvld_ex0)
    );

    function automatic logic [31:0] lcg_step(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Low LCG bits repeat quickly, so only the upper halves are used
    task automatic next_random(output logic [31:0] value);
        logic [15:0] hi;
        lcg_state = lcg_step(lcg_state);
        hi        = lcg_state[31:16];
        lcg_state = lcg_step(lcg_state);
        value     = {hi, lcg_state[31:16]};
    endtask

    function automatic common_pkg::t_rv_reg_data corner_value(logic [2:0] sel);
        case (sel)
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hFFFF_FFFF;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7FFF_FFFF;
            3'd4:    return 32'h0000_0001;
            default: return 32'h0000_001F;
        endcase
    endfunction

    task automatic random_operand(output common_pkg::t_rv_reg_data value);
        logic [31:0] r;
        next_random(r);
        if (r[3:0] < 4'd4) begin
            value = corner_value(r[6:4]);
        end else begin
            next_random(value);
        end
    endtask

    task automatic random_instr(output instr_pkg::t_uinstr ui);
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] pc;
        next_random(r);
        random_operand(imm);
        next_random(pc);
        ui.valid       = (r[2:0] != 3'd0);
        ui.uop         = instr_pkg::t_uop'(r[7:3] % 5'd20);
        ui.src2_optype = (r[9:8] == 2'd3) ? instr_pkg::OP_REG : instr_pkg::t_optype'(r[9:8]);
        ui.imm32       = imm;
        ui.pc          = {pc[31:2], 2'b00};
        ui.rd          = r[14:10];
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset still asserted after %0d cycles", cycles);
        end
    endtask

    task automatic run_stimulus();
        int                       cycles;
        logic [31:0]              r;
        instr_pkg::t_uinstr       ui;
        common_pkg::t_rv_reg_data a;
        common_pkg::t_rv_reg_data b;
        cycles = 0;
        while (issued < NUM_INSTR && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            next_random(r);
            // Upstream holds its inputs while stalled
            if (r[2:0] == 3'd0) begin
                stall <= 1'b1;
                stalled++;
            end else begin
                random_instr(ui);
                random_operand(a);
                random_operand(b);
                stall       <= 1'b0;
                uinstr_rd1  <= ui;
                rddata0_rd1 <= a;
                rddata1_rd1 <= b;
                issued++;
            end
        end
        if (issued < NUM_INSTR) begin
            timeouts++;
            $display("Timeout: only %0d of %0d instructions issued", issued, NUM_INSTR);
        end
    endtask

    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        stall <= 1'b0;
        @(negedge clk);
        while (uinstr_ex1 != uinstr_rd1 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (uinstr_ex1 != uinstr_rd1) begin
            timeouts++;
            $display("Timeout: last instruction never reached EX1");
        end
        // Last negedge checks have settled by the next rising edge
        @(posedge clk);
    endtask

    initial begin
        stall       = 1'b0;
        uinstr_rd1  = '0;
        rddata0_rd1 = '0;
        rddata1_rd1 = '0;
        issued      = 0;
        stalled     = 0;
        timeouts    = 0;
        wait_for_reset();
        if (timeouts == 0) begin
            run_stimulus();
            drain_pipeline();
        end
        assert_errors = u_exe_top.u_exe_assertions.error_count;
        $display("Issued %0d instructions, %0d stall cycles, %0d timeouts, %0d errors",
                 issued, stalled, timeouts, assert_errors);
        if (timeouts == 0 && assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/common_pkg.sv
design/instr_pkg.sv
design/exe_unit_if.sv
design/exe_stage_reg.sv
design/ialu.sv
design/ibr.sv
design/exe.sv
design/exe_top.sv
tests/exe_clock_gen.sv
tests/exe_assertions.sv
tests/exe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module exe_tb \
    -Mdir obj_dir -o exe_tb_sim

# Let every assertion failure be counted instead of stopping at the first
./obj_dir/exe_tb_sim +verilator+error+limit+100000 | tee "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
